// File: logic/snq_pkg.sv
// snoop queue shared definitions: widths, snoop types, tag FSM states, response bits
`default_nettype none

package snq_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int PA_W        = 40;
  // stored address is 128-bit aligned
  localparam int LINE_ADDR_W = PA_W - 4;
  localparam int DEPD_W      = 10;

  // cache index bits of the physical address
  localparam int IDX_LO = 6;
  localparam int IDX_HI = 13;

  typedef logic [PA_W-1:0]        pa_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // ------------------------------
  // snoop request types
  // ------------------------------
  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_SHARED  = 4'b1000,
    CLEAN_INVALID = 4'b1001,
    MAKE_INVALID  = 4'b1101
  } snq_type_e;

  // coherence response and its bit positions
  typedef logic [4:0] snq_resp_t;
  localparam int RESP_DT     = 0;
  localparam int RESP_ERR    = 1;
  localparam int RESP_PD     = 2;
  localparam int RESP_SHARED = 3;
  localparam int RESP_WU     = 4;

  // snoop-tag FSM, one-hot
  typedef enum logic [4:0] {
    IDLE           = 5'b00001,
    WAIT_RESP      = 5'b00010,
    SDT_REQ        = 5'b00100,
    WAIT_SDT_CMPLT = 5'b01000,
    WAIT_POP       = 5'b10000
  } snpt_state_e;

endpackage

`default_nettype wire

// File: logic/snq_entry_if.sv
// snoop queue entry status shared by the storage, response and tag FSM blocks
`timescale 1ns/1ps
`default_nettype none

interface snq_entry_if;

  // entry status, owned by the storage block
  logic                vld;
  snq_pkg::snq_type_e  snq_type;
  logic                issued;

  // sequencing strobes from the tag FSM
  logic                tag_issue;
  logic                pop;

  modport store (
    output vld,
    output snq_type,
    output issued,
    input  tag_issue,
    input  pop
  );

  modport fsm (
    output tag_issue,
    output pop,
    input  vld
  );

  modport resp (
    input  snq_type
  );

endinterface

`default_nettype wire

// File: logic/snq_entry_store.sv
// snoop queue entry storage: valid, address, type, dependencies, issued and index hits
`timescale 1ns/1ps
`default_nettype none

module snq_entry_store #(
  parameter int DEPD_W = snq_pkg::DEPD_W
) (
  input  logic                       snqctrlclk,
  input  logic                       cpurst_b,
  input  logic                       create_en,
  input  snq_pkg::pa_t               create_addr,
  input  snq_pkg::snq_type_e         create_type,
  input  logic [DEPD_W-1:0]          create_depd,
  input  logic [DEPD_W-1:0]          depd_remove,
  input  snq_pkg::pa_t               wmb_write_addr,
  input  logic [DEPD_W-3:0]          wmb_write_ptr,
  input  snq_pkg::pa_t               wmb_read_addr,
  input  logic [snq_pkg::PA_W-7:0]   lfb_vb_addr,
  output snq_pkg::line_addr_t        entry_addr,
  output logic                       rd_tag_rdy,
  output logic [1:0]                 depd_vb_id,
  output logic                       wmb_write_hit,
  output logic                       wmb_read_hit,
  output logic                       lfb_vb_hit,
  snq_entry_if.store                 status
);

  // write buffer pointer covers dependency bits 2 and up
  localparam int PTR_W = DEPD_W - 2;
  localparam int IDX_W = snq_pkg::IDX_HI - snq_pkg::IDX_LO + 1;

  logic [DEPD_W-1:0] depd;
  logic [IDX_W-1:0]  entry_idx;

  // ------------------------------
  // valid, type, issued
  // ------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      status.vld      <= 1'b0;
      status.snq_type <= snq_pkg::READ_ONCE;
      status.issued   <= 1'b0;
    end
    else
    begin
      if (create_en)
      begin
        status.vld      <= 1'b1;
        status.snq_type <= create_type;
      end
      else if (status.pop)
        status.vld <= 1'b0;

      if (status.pop)
        status.issued <= 1'b0;
      else if (status.tag_issue)
        status.issued <= 1'b1;
    end
  end

  // dependencies drop out bit by bit
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      depd <= '0;
    else if (create_en)
      depd <= create_depd;
    else
      depd <= depd & ~depd_remove;
  end

  // line address, 128-bit aligned
  always_ff @(posedge snqctrlclk)
  begin
    if (create_en)
      entry_addr <= create_addr[snq_pkg::PA_W-1:4];
  end

  assign rd_tag_rdy = status.vld && !(|depd) && !status.issued;

  // evict deadlock avoidance
  assign depd_vb_id = {2{status.vld}} & depd[1:0];

  // ------------------------------
  // index hit compare
  // ------------------------------
  assign entry_idx = entry_addr[snq_pkg::IDX_HI-4:snq_pkg::IDX_LO-4];

  // no hit on a write this entry still depends on
  assign wmb_write_hit = status.vld
                         && (entry_idx == wmb_write_addr[snq_pkg::IDX_HI:snq_pkg::IDX_LO])
                         && (|(~depd[DEPD_W-1:2] & wmb_write_ptr[PTR_W-1:0]));

  assign wmb_read_hit  = status.vld
                         && (entry_idx == wmb_read_addr[snq_pkg::IDX_HI:snq_pkg::IDX_LO]);

  // line-fill/victim address already starts at bit 6
  assign lfb_vb_hit    = status.vld
                         && (entry_idx == lfb_vb_addr[IDX_W-1:0]);

endmodule

`default_nettype wire

// File: logic/snq_resp_gen.sv
// snoop response decode: tag response to coherence response and data/tag step needs
`timescale 1ns/1ps
`default_nettype none

module snq_resp_gen (
  input  logic                snqctrlclk,
  input  logic                cpurst_b,
  input  logic                save_resp,
  input  logic                tag_resp_valid,
  input  logic                tag_resp_dirty,
  input  logic                tag_resp_share,
  input  logic                tag_resp_way,
  input  logic                ecc_err,
  output logic                need_snpdt,
  output snq_pkg::snq_resp_t  cr_resp,
  output logic                snq_way,
  output logic                need_read_data,
  output logic                need_chg_tag,
  output logic                need_chg_tag_s,
  output logic                need_chg_tag_i,
  output logic                tag_req_for_inv,
  snq_entry_if.resp           status
);

  logic typ_ro, typ_rs, typ_ru, typ_cs, typ_ci, typ_mi;
  logic line_m;
  logic data_transfer, pass_dirty, is_shared;
  logic chg_m, chg_s, chg_i;
  snq_pkg::snq_resp_t resp_nxt;

  // type decode
  assign typ_ro = (status.snq_type == snq_pkg::READ_ONCE);
  assign typ_rs = (status.snq_type == snq_pkg::READ_SHARED);
  assign typ_ru = (status.snq_type == snq_pkg::READ_UNIQUE);
  assign typ_cs = (status.snq_type == snq_pkg::CLEAN_SHARED);
  assign typ_ci = (status.snq_type == snq_pkg::CLEAN_INVALID);
  assign typ_mi = (status.snq_type == snq_pkg::MAKE_INVALID);

  // ------------------------------
  // coherence response
  // ------------------------------
  // M state, only M lines transfer data
  assign line_m        = tag_resp_valid && tag_resp_dirty;
  assign data_transfer = line_m && !typ_mi;
  assign pass_dirty    = line_m && (typ_rs || typ_ru || typ_cs || typ_ci);
  assign is_shared     = tag_resp_valid && (typ_rs || typ_ro || typ_cs);

  always_comb
  begin
    resp_nxt                       = '0;
    resp_nxt[snq_pkg::RESP_DT]     = data_transfer;
    resp_nxt[snq_pkg::RESP_ERR]    = ecc_err;
    resp_nxt[snq_pkg::RESP_PD]     = pass_dirty;
    resp_nxt[snq_pkg::RESP_SHARED] = is_shared;
    // was unique not supported
    resp_nxt[snq_pkg::RESP_WU]     = 1'b0;
  end

  // ------------------------------
  // data/tag step needs
  // ------------------------------
  assign tag_req_for_inv = typ_ru || typ_ci || typ_mi;
  assign chg_i = tag_resp_valid && tag_req_for_inv;
  assign chg_s = tag_resp_valid && !tag_resp_share && (typ_rs || typ_cs);
  assign chg_m = line_m && typ_cs;

  assign need_snpdt = data_transfer || chg_m || chg_s || chg_i;

  always_ff @(posedge snqctrlclk)
  begin
    if (save_resp)
    begin
      cr_resp <= resp_nxt;
      snq_way <= tag_resp_way;
    end
  end

  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      need_read_data <= 1'b0;
      need_chg_tag   <= 1'b0;
      need_chg_tag_s <= 1'b0;
      need_chg_tag_i <= 1'b0;
    end
    else if (save_resp)
    begin
      need_read_data <= data_transfer;
      need_chg_tag   <= chg_m || chg_s || chg_i;
      need_chg_tag_s <= chg_s;
      need_chg_tag_i <= chg_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/snq_tag_fsm.sv
// snoop tag FSM: tag read, data/tag step and response pop for one entry
`timescale 1ns/1ps
`default_nettype none

module snq_tag_fsm (
  input  logic        snqctrlclk,
  input  logic        cpurst_b,
  input  logic        tag_start,
  input  logic        tag_grnt,
  input  logic        resp_create_en,
  input  logic        need_snpdt,
  input  logic        snpdt_grnt,
  input  logic        snpdt_cmplt,
  input  logic        oldest,
  input  logic        cr_resp_acept,
  output logic        save_resp,
  output logic        snpdt_start,
  output logic        cr_resp_valid,
  snq_entry_if.fsm    status
);

  snq_pkg::snpt_state_e state;
  snq_pkg::snpt_state_e state_nxt;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= snq_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // ------------------------------
  // strobes from state
  // ------------------------------
  // tag read granted for a live entry
  assign status.tag_issue = (state == snq_pkg::IDLE) && status.vld
                            && tag_start && tag_grnt;

  assign save_resp     = (state == snq_pkg::WAIT_RESP) && resp_create_en;
  assign snpdt_start   = (state == snq_pkg::SDT_REQ) && oldest;
  assign cr_resp_valid = (state == snq_pkg::WAIT_POP) && oldest;
  assign status.pop    = cr_resp_valid && cr_resp_acept;

  // ------------------------------
  // next state
  // ------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      snq_pkg::IDLE:
      begin
        if (status.tag_issue)
          state_nxt = snq_pkg::WAIT_RESP;
      end
      snq_pkg::WAIT_RESP:
      begin
        // read data and/or tag change first
        if (save_resp)
          state_nxt = need_snpdt ? snq_pkg::SDT_REQ : snq_pkg::WAIT_POP;
      end
      snq_pkg::SDT_REQ:
      begin
        if (snpdt_start && snpdt_grnt)
          state_nxt = snq_pkg::WAIT_SDT_CMPLT;
      end
      snq_pkg::WAIT_SDT_CMPLT:
      begin
        if (snpdt_cmplt)
          state_nxt = snq_pkg::WAIT_POP;
      end
      snq_pkg::WAIT_POP:
      begin
        if (status.pop)
          state_nxt = snq_pkg::IDLE;
      end
      default:
        state_nxt = snq_pkg::IDLE;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/snq_entry.sv
// snoop queue entry top: storage, response decode and tag FSM on plain ports
`timescale 1ns/1ps
`default_nettype none

module snq_entry #(
  parameter int DEPD_W = snq_pkg::DEPD_W
) (
  input  logic                      snqctrlclk,
  input  logic                      cpurst_b,
  input  logic                      create_en,
  input  snq_pkg::pa_t              create_addr,
  input  snq_pkg::snq_type_e        create_type,
  input  logic [DEPD_W-1:0]         create_depd,
  input  logic [DEPD_W-1:0]         depd_remove,
  input  logic                      tag_start,
  input  logic                      tag_grnt,
  input  logic                      resp_create_en,
  input  logic                      tag_resp_valid,
  input  logic                      tag_resp_dirty,
  input  logic                      tag_resp_share,
  input  logic                      tag_resp_way,
  input  logic                      ecc_err,
  input  logic                      snpdt_grnt,
  input  logic                      snpdt_cmplt,
  input  logic                      oldest,
  input  logic                      cr_resp_acept,
  input  snq_pkg::pa_t              wmb_write_addr,
  input  logic [DEPD_W-3:0]         wmb_write_ptr,
  input  snq_pkg::pa_t              wmb_read_addr,
  input  logic [snq_pkg::PA_W-7:0]  lfb_vb_addr,
  output logic                      snq_vld,
  output logic                      rd_tag_rdy,
  output snq_pkg::line_addr_t       entry_addr,
  output logic                      issued,
  output logic [1:0]                depd_vb_id,
  output logic                      snpdt_start,
  output logic                      need_read_data,
  output logic                      need_chg_tag,
  output logic                      need_chg_tag_s,
  output logic                      need_chg_tag_i,
  output logic                      tag_req_for_inv,
  output logic                      snq_way,
  output logic                      cr_resp_valid,
  output snq_pkg::snq_resp_t        cr_resp,
  output logic                      wmb_write_hit,
  output logic                      wmb_read_hit,
  output logic                      lfb_vb_hit
);

  logic need_snpdt;
  logic save_resp;

  snq_entry_if u_if ();

  assign snq_vld = u_if.vld;
  assign issued  = u_if.issued;

  // ------------------------------
  // entry storage
  // ------------------------------
  snq_entry_store #(
    .DEPD_W (DEPD_W)
  ) u_store (
    .snqctrlclk     (snqctrlclk),
    .cpurst_b       (cpurst_b),
    .create_en      (create_en),
    .create_addr    (create_addr),
    .create_type    (create_type),
    .create_depd    (create_depd),
    .depd_remove    (depd_remove),
    .wmb_write_addr (wmb_write_addr),
    .wmb_write_ptr  (wmb_write_ptr),
    .wmb_read_addr  (wmb_read_addr),
    .lfb_vb_addr    (lfb_vb_addr),
    .entry_addr     (entry_addr),
    .rd_tag_rdy     (rd_tag_rdy),
    .depd_vb_id     (depd_vb_id),
    .wmb_write_hit  (wmb_write_hit),
    .wmb_read_hit   (wmb_read_hit),
    .lfb_vb_hit     (lfb_vb_hit),
    .status         (u_if.store)
  );

  // response decode
  snq_resp_gen u_resp (
    .snqctrlclk      (snqctrlclk),
    .cpurst_b        (cpurst_b),
    .save_resp       (save_resp),
    .tag_resp_valid  (tag_resp_valid),
    .tag_resp_dirty  (tag_resp_dirty),
    .tag_resp_share  (tag_resp_share),
    .tag_resp_way    (tag_resp_way),
    .ecc_err         (ecc_err),
    .need_snpdt      (need_snpdt),
    .cr_resp         (cr_resp),
    .snq_way         (snq_way),
    .need_read_data  (need_read_data),
    .need_chg_tag    (need_chg_tag),
    .need_chg_tag_s  (need_chg_tag_s),
    .need_chg_tag_i  (need_chg_tag_i),
    .tag_req_for_inv (tag_req_for_inv),
    .status          (u_if.resp)
  );

  // tag FSM
  snq_tag_fsm u_fsm (
    .snqctrlclk     (snqctrlclk),
    .cpurst_b       (cpurst_b),
    .tag_start      (tag_start),
    .tag_grnt       (tag_grnt),
    .resp_create_en (resp_create_en),
    .need_snpdt     (need_snpdt),
    .snpdt_grnt     (snpdt_grnt),
    .snpdt_cmplt    (snpdt_cmplt),
    .oldest         (oldest),
    .cr_resp_acept  (cr_resp_acept),
    .save_resp      (save_resp),
    .snpdt_start    (snpdt_start),
    .cr_resp_valid  (cr_resp_valid),
    .status         (u_if.fsm)
  );

endmodule

`default_nettype wire

// File: verif/tb_snq_entry.sv
// table-driven testbench for the snoop queue entry covering create, tag read, data/tag step, pop and hits
`timescale 1ns/1ps
`default_nettype none

module tb_snq_entry;

  localparam int DEPD_W  = snq_pkg::DEPD_W;
  localparam int ROWS    = 12;
  localparam int TIMEOUT = 50;

  typedef struct packed {
    snq_pkg::snq_type_e typ;
    logic [DEPD_W-1:0]  depd;
    logic               tvld;
    logic               dirty;
    logic               share;
    logic               way;
    logic               ecc;
    logic [1:0]         old_dly;
    snq_pkg::snq_resp_t resp;
    // snpdt, read data, chg tag, chg s, chg i
    logic [4:0]         need;
    logic               inv;
  } row_t;

  logic snqctrlclk;
  logic cpurst_b;
  logic create_en;
  snq_pkg::pa_t create_addr;
  snq_pkg::snq_type_e create_type;
  logic [DEPD_W-1:0] create_depd;
  logic [DEPD_W-1:0] depd_remove;
  logic tag_start, tag_grnt, resp_create_en;
  logic tag_resp_valid, tag_resp_dirty, tag_resp_share, tag_resp_way, ecc_err;
  logic snpdt_grnt, snpdt_cmplt, oldest, cr_resp_acept;
  snq_pkg::pa_t wmb_write_addr;
  logic [DEPD_W-3:0] wmb_write_ptr;
  snq_pkg::pa_t wmb_read_addr;
  logic [snq_pkg::PA_W-7:0] lfb_vb_addr;

  logic snq_vld, rd_tag_rdy, issued, snpdt_start, snq_way, cr_resp_valid;
  snq_pkg::line_addr_t entry_addr;
  logic [1:0] depd_vb_id;
  logic need_read_data, need_chg_tag, need_chg_tag_s, need_chg_tag_i, tag_req_for_inv;
  snq_pkg::snq_resp_t cr_resp;
  logic wmb_write_hit, wmb_read_hit, lfb_vb_hit;

  row_t rows [ROWS];
  logic [31:0] seed;

  snq_entry #(
    .DEPD_W (DEPD_W)
  ) u_dut (
    .snqctrlclk      (snqctrlclk),
    .cpurst_b        (cpurst_b),
    .create_en       (create_en),
    .create_addr     (create_addr),
    .create_type     (create_type),
    .create_depd     (create_depd),
    .depd_remove     (depd_remove),
    .tag_start       (tag_start),
    .tag_grnt        (tag_grnt),
    .resp_create_en  (resp_create_en),
    .tag_resp_valid  (tag_resp_valid),
    .tag_resp_dirty  (tag_resp_dirty),
    .tag_resp_share  (tag_resp_share),
    .tag_resp_way    (tag_resp_way),
    .ecc_err         (ecc_err),
    .snpdt_grnt      (snpdt_grnt),
    .snpdt_cmplt     (snpdt_cmplt),
    .oldest          (oldest),
    .cr_resp_acept   (cr_resp_acept),
    .wmb_write_addr  (wmb_write_addr),
    .wmb_write_ptr   (wmb_write_ptr),
    .wmb_read_addr   (wmb_read_addr),
    .lfb_vb_addr     (lfb_vb_addr),
    .snq_vld         (snq_vld),
    .rd_tag_rdy      (rd_tag_rdy),
    .entry_addr      (entry_addr),
    .issued          (issued),
    .depd_vb_id      (depd_vb_id),
    .snpdt_start     (snpdt_start),
    .need_read_data  (need_read_data),
    .need_chg_tag    (need_chg_tag),
    .need_chg_tag_s  (need_chg_tag_s),
    .need_chg_tag_i  (need_chg_tag_i),
    .tag_req_for_inv (tag_req_for_inv),
    .snq_way         (snq_way),
    .cr_resp_valid   (cr_resp_valid),
    .cr_resp         (cr_resp),
    .wmb_write_hit   (wmb_write_hit),
    .wmb_read_hit    (wmb_read_hit),
    .lfb_vb_hit      (lfb_vb_hit)
  );

  always #10 snqctrlclk = ~snqctrlclk;

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift32(seed);
    return seed;
  endfunction

  // random address with the given cache index
  function automatic snq_pkg::pa_t addr_with_idx(input logic [7:0] idx);
    logic [31:0] r1;
    logic [31:0] r2;
    snq_pkg::pa_t a;
    r1 = next_rand();
    r2 = next_rand();
    a = {r1[7:0], r2};
    a[13:6] = idx;
    return a;
  endfunction

  task automatic stop_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_vec(input string what, input logic [39:0] got, input logic [39:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s never came", what);
    stop_run();
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic fill_table();
    // type, depd, valid, dirty, share, way, ecc, oldest delay, resp, needs, inv
    rows[0]  = '{snq_pkg::READ_ONCE, 10'h000, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 2'd1,
                 5'b01001, 5'b11000, 1'b0};
    rows[1]  = '{snq_pkg::READ_ONCE, 10'h3ff, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0,
                 5'b01000, 5'b00000, 1'b0};
    rows[2]  = '{snq_pkg::READ_SHARED, 10'h005, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd2,
                 5'b01101, 5'b11110, 1'b0};
    rows[3]  = '{snq_pkg::READ_SHARED, 10'h2a0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 2'd3,
                 5'b01000, 5'b00000, 1'b0};
    rows[4]  = '{snq_pkg::READ_UNIQUE, 10'h101, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 2'd1,
                 5'b00101, 5'b11101, 1'b1};
    rows[5]  = '{snq_pkg::CLEAN_SHARED, 10'h0f3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd0,
                 5'b01111, 5'b11110, 1'b0};
    rows[6]  = '{snq_pkg::CLEAN_INVALID, 10'h010, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 2'd2,
                 5'b00000, 5'b10101, 1'b1};
    rows[7]  = '{snq_pkg::MAKE_INVALID, 10'h3c2, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
                 5'b00000, 5'b10101, 1'b1};
    // invalid line gives only the error bit
    rows[8]  = '{snq_pkg::READ_UNIQUE, 10'h002, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 2'd0,
                 5'b00010, 5'b00000, 1'b1};
    rows[9]  = '{snq_pkg::CLEAN_SHARED, 10'h180, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd3,
                 5'b01000, 5'b00000, 1'b0};
    rows[10] = '{snq_pkg::CLEAN_INVALID, 10'h0c0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 2'd2,
                 5'b00101, 5'b11101, 1'b1};
    rows[11] = '{snq_pkg::READ_SHARED, 10'h044, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1,
                 5'b01000, 5'b10110, 1'b0};
  endtask

  // matching, masked and mismatching index compares
  task automatic check_hits(input logic [DEPD_W-1:0] depd_now, input logic [7:0] idx);
    logic [31:0] r;
    logic [2:0] pos;
    logic [7:0] ptr;
    logic [7:0] flip;
    r = next_rand();
    pos = r[2:0];
    ptr = 8'h01 << pos;
    flip = r[15:8] | 8'h01;
    @(posedge snqctrlclk);
    wmb_write_addr <= addr_with_idx(idx);
    wmb_write_ptr  <= ptr;
    wmb_read_addr  <= addr_with_idx(idx);
    lfb_vb_addr    <= {r[31:6], idx};
    @(negedge snqctrlclk);
    // a single pointer bit hits only where its dependency bit is clear
    check_bit("wmb_write_hit", wmb_write_hit, !depd_now[int'(pos) + 2]);
    check_bit("wmb_read_hit", wmb_read_hit, 1'b1);
    check_bit("lfb_vb_hit", lfb_vb_hit, 1'b1);
    @(posedge snqctrlclk);
    wmb_write_ptr <= depd_now[DEPD_W-1:2];
    @(negedge snqctrlclk);
    check_bit("masked wmb_write_hit", wmb_write_hit, 1'b0);
    @(posedge snqctrlclk);
    wmb_write_addr <= addr_with_idx(idx ^ flip);
    wmb_write_ptr  <= '1;
    wmb_read_addr  <= addr_with_idx(idx ^ flip);
    lfb_vb_addr    <= {r[31:6], idx ^ flip};
    @(negedge snqctrlclk);
    check_vec("hits on other index", 40'({wmb_write_hit, wmb_read_hit, lfb_vb_hit}), 40'(0));
  endtask

  // ------------------------------
  // one snoop through the entry
  // ------------------------------
  task automatic run_row(input row_t rw);
    logic [31:0] r;
    snq_pkg::pa_t addr;
    logic [DEPD_W-1:0] depd_now;
    logic [DEPD_W-1:0] mask;
    int dly;
    int n;
    r = next_rand();
    addr = addr_with_idx(r[7:0]);
    depd_now = rw.depd;
    @(posedge snqctrlclk);
    create_en   <= 1'b1;
    create_addr <= addr;
    create_type <= rw.typ;
    create_depd <= rw.depd;
    @(posedge snqctrlclk);
    create_en <= 1'b0;
    @(negedge snqctrlclk);
    check_bit("snq_vld", snq_vld, 1'b1);
    check_vec("entry_addr", 40'(entry_addr), 40'(addr[39:4]));
    check_bit("tag_req_for_inv", tag_req_for_inv, rw.inv);
    check_vec("depd_vb_id", 40'(depd_vb_id), 40'(depd_now[1:0]));
    check_hits(depd_now, addr[13:6]);

    // drop dependencies from the highest bit down
    for (int i = DEPD_W - 1; i >= 0; i--)
    begin
      if (depd_now[i])
      begin
        check_bit("rd_tag_rdy with dependency", rd_tag_rdy, 1'b0);
        mask = '0;
        mask[i] = 1'b1;
        @(posedge snqctrlclk);
        depd_remove <= mask;
        @(posedge snqctrlclk);
        depd_remove <= '0;
        depd_now[i] = 1'b0;
        @(negedge snqctrlclk);
        check_vec("depd_vb_id", 40'(depd_vb_id), 40'(depd_now[1:0]));
      end
    end
    check_bit("rd_tag_rdy", rd_tag_rdy, 1'b1);
    check_hits(depd_now, addr[13:6]);

    // tag read with the grant held back
    r = next_rand();
    dly = int'(r[1:0]);
    @(posedge snqctrlclk);
    tag_start <= 1'b1;
    repeat (dly)
    begin
      @(negedge snqctrlclk);
      check_bit("issued before grant", issued, 1'b0);
    end
    @(posedge snqctrlclk);
    tag_grnt <= 1'b1;
    @(posedge snqctrlclk);
    tag_start <= 1'b0;
    tag_grnt  <= 1'b0;
    @(negedge snqctrlclk);
    check_bit("issued", issued, 1'b1);
    check_bit("rd_tag_rdy after issue", rd_tag_rdy, 1'b0);

    // tag response followed by flipped inputs that must not disturb it
    @(posedge snqctrlclk);
    resp_create_en <= 1'b1;
    tag_resp_valid <= rw.tvld;
    tag_resp_dirty <= rw.dirty;
    tag_resp_share <= rw.share;
    tag_resp_way   <= rw.way;
    ecc_err        <= rw.ecc;
    @(posedge snqctrlclk);
    resp_create_en <= 1'b0;
    tag_resp_valid <= ~rw.tvld;
    tag_resp_dirty <= ~rw.dirty;
    tag_resp_share <= ~rw.share;
    tag_resp_way   <= ~rw.way;
    ecc_err        <= ~rw.ecc;
    @(negedge snqctrlclk);
    check_vec("cr_resp", 40'(cr_resp), 40'(rw.resp));
    check_bit("snq_way", snq_way, rw.way);
    check_vec("need flags", 40'({need_read_data, need_chg_tag, need_chg_tag_s, need_chg_tag_i}),
              40'(rw.need[3:0]));

    if (rw.need[4])
    begin
      repeat (rw.old_dly)
      begin
        @(negedge snqctrlclk);
        check_bit("snpdt_start while not oldest", snpdt_start, 1'b0);
      end
      @(posedge snqctrlclk);
      oldest <= 1'b1;
      n = 0;
      @(negedge snqctrlclk);
      while (!snpdt_start)
      begin
        n++;
        if (n > TIMEOUT)
          report_timeout("snpdt_start");
        @(negedge snqctrlclk);
      end
      r = next_rand();
      dly = int'(r[1:0]);
      repeat (dly)
      begin
        @(negedge snqctrlclk);
        check_bit("snpdt_start held", snpdt_start, 1'b1);
      end
      @(posedge snqctrlclk);
      snpdt_grnt <= 1'b1;
      @(posedge snqctrlclk);
      snpdt_grnt <= 1'b0;
      oldest     <= 1'b0;
      @(negedge snqctrlclk);
      check_bit("snpdt_start after grant", snpdt_start, 1'b0);
      r = next_rand();
      dly = int'(r[1:0]);
      repeat (dly)
      begin
        @(negedge snqctrlclk);
        check_bit("cr_resp_valid before cmplt", cr_resp_valid, 1'b0);
      end
      @(posedge snqctrlclk);
      snpdt_cmplt <= 1'b1;
      @(posedge snqctrlclk);
      snpdt_cmplt <= 1'b0;
    end

    // response waits for oldest
    repeat (rw.old_dly)
    begin
      @(negedge snqctrlclk);
      check_bit("cr_resp_valid while not oldest", cr_resp_valid, 1'b0);
    end
    @(posedge snqctrlclk);
    oldest <= 1'b1;
    n = 0;
    @(negedge snqctrlclk);
    while (!cr_resp_valid)
    begin
      n++;
      if (n > TIMEOUT)
        report_timeout("cr_resp_valid");
      @(negedge snqctrlclk);
    end
    check_bit("snpdt_start in pop", snpdt_start, 1'b0);
    r = next_rand();
    dly = int'(r[1:0]);
    repeat (dly)
    begin
      @(negedge snqctrlclk);
      check_bit("cr_resp_valid held", cr_resp_valid, 1'b1);
      check_vec("cr_resp held", 40'(cr_resp), 40'(rw.resp));
    end
    @(posedge snqctrlclk);
    cr_resp_acept <= 1'b1;
    @(posedge snqctrlclk);
    cr_resp_acept <= 1'b0;
    oldest        <= 1'b0;
    @(negedge snqctrlclk);
    check_vec("entry after pop", 40'({snq_vld, issued, cr_resp_valid}), 40'(0));
  endtask

  initial
  begin
    seed = 32'he258_b142;
    snqctrlclk = 1'b0;
    cpurst_b = 1'b0;
    create_en = 1'b0;
    create_addr = '0;
    create_type = snq_pkg::READ_ONCE;
    create_depd = '0;
    depd_remove = '0;
    tag_start = 1'b0;
    tag_grnt = 1'b0;
    resp_create_en = 1'b0;
    tag_resp_valid = 1'b0;
    tag_resp_dirty = 1'b0;
    tag_resp_share = 1'b0;
    tag_resp_way = 1'b0;
    ecc_err = 1'b0;
    snpdt_grnt = 1'b0;
    snpdt_cmplt = 1'b0;
    oldest = 1'b0;
    cr_resp_acept = 1'b0;
    wmb_write_addr = '0;
    wmb_write_ptr = '1;
    wmb_read_addr = '0;
    lfb_vb_addr = '0;
    fill_table();

    repeat (4) @(posedge snqctrlclk);
    cpurst_b <= 1'b1;
    @(negedge snqctrlclk);
    check_vec("control outputs after reset",
              40'({snq_vld, rd_tag_rdy, issued, snpdt_start, cr_resp_valid, need_read_data,
                   need_chg_tag, need_chg_tag_s, need_chg_tag_i, wmb_write_hit, wmb_read_hit,
                   lfb_vb_hit, depd_vb_id}), 40'(0));

    for (int k = 0; k < ROWS; k++)
      run_row(rows[k]);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/snq_pkg.sv
logic/snq_entry_if.sv
logic/snq_entry_store.sv
logic/snq_resp_gen.sv
logic/snq_tag_fsm.sv
logic/snq_entry.sv
verif/tb_snq_entry.sv

// File: Makefile
# Verilator build and run for the snoop queue entry

VERILATOR ?= verilator
TOP       ?= tb_snq_entry
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
